// ==== design/cache_macros.svh ====
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// Address split  tag[31:10] | index[9:2] | offset[1:0]
`define CACHE_ADDR_W   32
`define CACHE_DATA_W   32   // One word per line

// Storage geometry, 4 KB total
`define CACHE_NUM_SETS 256
`define CACHE_NUM_WAYS 4

// Field widths of the address
`define CACHE_INDEX_W  8    // log2 of set count
`define CACHE_OFFSET_W 2    // Byte offset in a word
`define CACHE_TAG_W    22   // What is left above index

`endif

// ==== design/cache_pkg.sv ====
`include "cache_macros.svh"

package cache_pkg;

    // Fetch unit states
    typedef enum logic [1:0] {
        FETCH_IDLE = 2'd0,  // Waiting for a request, hits finish here
        FETCH_WAIT = 2'd1,  // Memory read outstanding
        FETCH_FILL = 2'd2   // Line written, repeat the lookup
    } fetch_state_e;

    // Way number inside a set
    typedef logic [$clog2(`CACHE_NUM_WAYS)-1:0] way_idx_t;

    // Per-way LRU age
    // 0 is most recent, saturates at ways-1
    typedef logic [$clog2(`CACHE_NUM_WAYS)-1:0] lru_age_t;

endpackage

// ==== design/bus_pkg.sv ====
`include "cache_macros.svh"

package bus_pkg;

    // Core access size, always in the low byte lanes
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } access_size_e;

    // Register port addresses
    typedef enum logic [1:0] {
        REG_CTRL   = 2'd0,  // Bit 0 enable, bit 1 flush
        REG_HITS   = 2'd1,
        REG_MISSES = 2'd2
    } cfg_reg_e;

    // Keep the low lanes of a word by size, zero-extended
    function automatic logic [`CACHE_DATA_W-1:0] size_extend(
        input logic [`CACHE_DATA_W-1:0] word,
        input access_size_e             size
    );
        case (size)
            SIZE_BYTE: return {{(`CACHE_DATA_W-8){1'b0}}, word[7:0]};
            SIZE_HALF: return {{(`CACHE_DATA_W-16){1'b0}}, word[15:0]};
            default:   return word;
        endcase
    endfunction

endpackage

// ==== design/l1_cache_array.sv ====
`include "cache_macros.svh"

module l1_cache_array
    import cache_pkg::*;
    import bus_pkg::*;
(
    input  logic                     clk,
    input  logic                     arst_n_i,
    input  logic [`CACHE_ADDR_W-1:0] addr_i,
    input  logic                     wr_en_i,       // Merge write data on a hit
    input  access_size_e             size_i,
    input  logic [`CACHE_DATA_W-1:0] wr_data_i,
    input  logic                     lookup_i,      // Access presented this cycle
    input  logic                     fill_en_i,     // Line arrives from memory
    input  logic [`CACHE_DATA_W-1:0] fill_data_i,
    input  logic                     flush_i,       // Drop all lines
    output logic                     hit_o,
    output logic [`CACHE_DATA_W-1:0] rd_data_o
);

    localparam lru_age_t AGE_MAX = lru_age_t'(`CACHE_NUM_WAYS - 1);

    // Line storage with one word per way
    logic [`CACHE_TAG_W-1:0]    tag_mem  [`CACHE_NUM_SETS][`CACHE_NUM_WAYS];
    logic [`CACHE_DATA_W-1:0]   data_mem [`CACHE_NUM_SETS][`CACHE_NUM_WAYS];

    // Control state cleared on reset
    logic [`CACHE_NUM_WAYS-1:0] valid_q  [`CACHE_NUM_SETS];
    lru_age_t                   age_q    [`CACHE_NUM_SETS][`CACHE_NUM_WAYS];

    // Address fields
    logic [`CACHE_TAG_W-1:0]    tag;
    logic [`CACHE_INDEX_W-1:0]  index;

    // Lookup results
    logic                       hit;
    way_idx_t                   hit_way;
    logic [`CACHE_DATA_W-1:0]   hit_word;
    logic [`CACHE_DATA_W-1:0]   merged_word;

    // Replacement choice
    way_idx_t                   victim_way;
    lru_age_t                   victim_age;

    // Age update
    logic                       age_touch;
    way_idx_t                   touch_way;
    lru_age_t                   touch_age;

    assign tag   = addr_i[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
    assign index = addr_i[`CACHE_OFFSET_W +: `CACHE_INDEX_W];    // Offset bits ignored

    // Compare all four ways of the set
    always_comb begin
        hit      = 1'b0;
        hit_way  = '0;
        hit_word = '0;
        for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
            if (valid_q[index][w] && (tag_mem[index][w] == tag)) begin
                hit      = 1'b1;
                hit_way  = way_idx_t'(w);
                hit_word = data_mem[index][w];
            end
        end
    end

    assign hit_o     = hit;
    assign rd_data_o = size_extend(hit_word, size_i);   // Zero-extend by size

    // Oldest way wins
    // strict compare keeps the lowest way on a tie
    always_comb begin
        victim_way = '0;
        victim_age = age_q[index][0];
        for (int w = 1; w < `CACHE_NUM_WAYS; w++) begin
            if (age_q[index][w] > victim_age) begin
                victim_age = age_q[index][w];
                victim_way = way_idx_t'(w);
            end
        end
    end

    // Write data into the low lanes of the hit word
    always_comb begin
        merged_word = hit_word;
        case (size_i)
            SIZE_BYTE: merged_word[7:0]  = wr_data_i[7:0];
            SIZE_HALF: merged_word[15:0] = wr_data_i[15:0];
            default:   merged_word       = wr_data_i;
        endcase
    end

    // A fill or a hit makes that way the newest
    assign age_touch = fill_en_i || (lookup_i && hit);
    assign touch_way = fill_en_i ? victim_way : hit_way;
    assign touch_age = age_q[index][touch_way];

    // Valid bits and ages
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int s = 0; s < `CACHE_NUM_SETS; s++) begin
                valid_q[s] <= '0;
                for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
                    age_q[s][w] <= '0;
                end
            end
        end else if (flush_i) begin
            for (int s = 0; s < `CACHE_NUM_SETS; s++) begin
                valid_q[s] <= '0;                       // Lines dropped but ages kept
            end
        end else begin
            if (fill_en_i) begin
                valid_q[index][victim_way] <= 1'b1;
            end
            if (age_touch) begin
                // Fill ages every other way
                // a hit only ages the ways newer than the touched one
                for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
                    if (way_idx_t'(w) == touch_way) begin
                        age_q[index][w] <= '0;          // Most recent
                    end else if (age_q[index][w] != AGE_MAX &&
                                 (fill_en_i || age_q[index][w] < touch_age)) begin
                        age_q[index][w] <= age_q[index][w] + 1'b1;
                    end
                end
            end
        end
    end

    // Tags and data
    always_ff @(posedge clk) begin
        if (fill_en_i) begin
            tag_mem[index][victim_way]  <= tag;
            data_mem[index][victim_way] <= fill_data_i;
        end else if (lookup_i && hit && wr_en_i) begin
            data_mem[index][hit_way]    <= merged_word;     // Write hit
        end
    end

endmodule

// ==== design/miss_fetch.sv ====
`include "cache_macros.svh"

module miss_fetch
    import cache_pkg::*;
    import bus_pkg::*;
(
    input  logic                     clk,
    input  logic                     arst_n_i,
    input  logic                     req_i,             // Held until done_o
    input  logic                     wr_en_i,
    input  logic [`CACHE_ADDR_W-1:0] addr_i,
    input  logic [`CACHE_DATA_W-1:0] wr_data_i,
    input  access_size_e             size_i,
    input  logic                     enable_i,
    input  logic                     hit_i,             // Combinational from array
    input  logic [`CACHE_DATA_W-1:0] array_rd_data_i,
    input  logic                     mem_valid_i,
    input  logic [`CACHE_DATA_W-1:0] mem_data_i,
    output logic                     done_o,
    output logic [`CACHE_DATA_W-1:0] rd_data_o,
    output logic                     lookup_o,
    output logic                     fill_en_o,
    output logic [`CACHE_DATA_W-1:0] fill_data_o,
    output logic                     mem_rd_o,
    output logic                     mem_wr_o,
    output logic [`CACHE_ADDR_W-1:0] mem_addr_o,
    output logic [`CACHE_DATA_W-1:0] mem_wdata_o,
    output access_size_e             mem_size_o,
    output logic                     hit_evt_o,
    output logic                     miss_evt_o
);

    fetch_state_e state_q, state_d;
    logic         bypass_q, bypass_d;   // Outstanding read skips the array

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q  <= FETCH_IDLE;
            bypass_q <= 1'b0;
        end else begin
            state_q  <= state_d;
            bypass_q <= bypass_d;
        end
    end

    always_comb begin
        state_d    = state_q;
        bypass_d   = bypass_q;
        done_o     = 1'b0;
        fill_en_o  = 1'b0;
        mem_rd_o   = 1'b0;
        mem_wr_o   = 1'b0;
        hit_evt_o  = 1'b0;
        miss_evt_o = 1'b0;
        case (state_q)
            FETCH_IDLE: begin
                if (req_i && enable_i && hit_i) begin
                    done_o    = 1'b1;               // Hit finishes at once
                    hit_evt_o = 1'b1;
                    mem_wr_o  = wr_en_i;            // Write-through
                end else if (req_i && enable_i) begin
                    miss_evt_o = 1'b1;
                    mem_rd_o   = 1'b1;              // Fetch line, also for writes
                    bypass_d   = 1'b0;
                    state_d    = FETCH_WAIT;
                end else if (req_i && wr_en_i) begin
                    done_o   = 1'b1;                // Disabled write goes straight out
                    mem_wr_o = 1'b1;
                end else if (req_i) begin
                    mem_rd_o = 1'b1;                // Disabled read
                    bypass_d = 1'b1;
                    state_d  = FETCH_WAIT;
                end
            end
            FETCH_WAIT: begin
                if (mem_valid_i && bypass_q) begin
                    done_o  = 1'b1;
                    state_d = FETCH_IDLE;
                end else if (mem_valid_i) begin
                    fill_en_o = 1'b1;               // Allocate into LRU way
                    state_d   = FETCH_FILL;
                end
            end
            FETCH_FILL: begin
                state_d = FETCH_IDLE;
                if (hit_i) begin
                    done_o   = 1'b1;
                    mem_wr_o = wr_en_i;             // Write miss merges here
                end
            end
            default: state_d = FETCH_IDLE;
        endcase
    end

    // Array is looked up on a first enabled cycle and after a fill
    assign lookup_o = req_i && ((state_q == FETCH_IDLE && enable_i) || state_q == FETCH_FILL);

    assign fill_data_o = mem_data_i;
    assign rd_data_o   = (state_q == FETCH_WAIT) ? size_extend(mem_data_i, size_i)
                                                 : array_rd_data_i;

    // Word-aligned memory address
    assign mem_addr_o  = {addr_i[`CACHE_ADDR_W-1:`CACHE_OFFSET_W], {`CACHE_OFFSET_W{1'b0}}};
    assign mem_wdata_o = wr_data_i;
    assign mem_size_o  = size_i;

endmodule

// ==== design/cache_cfg_regs.sv ====
`include "cache_macros.svh"

module cache_cfg_regs
    import bus_pkg::*;
(
    input  logic                     clk,
    input  logic                     arst_n_i,
    input  logic                     cfg_we_i,
    input  cfg_reg_e                 cfg_addr_i,
    input  logic [`CACHE_DATA_W-1:0] cfg_wdata_i,
    input  logic                     hit_evt_i,
    input  logic                     miss_evt_i,
    output logic [`CACHE_DATA_W-1:0] cfg_rdata_o,
    output logic                     enable_o,
    output logic                     flush_o
);

    logic                     enable_q;
    logic                     flush_q;      // Self-clearing
    logic [`CACHE_DATA_W-1:0] hits_q;
    logic [`CACHE_DATA_W-1:0] misses_q;

    // Control register
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            enable_q <= 1'b0;
            flush_q  <= 1'b0;
        end else if (cfg_we_i && cfg_addr_i == REG_CTRL) begin
            enable_q <= cfg_wdata_i[0];
            flush_q  <= cfg_wdata_i[1];     // High for one cycle only
        end else begin
            flush_q  <= 1'b0;
        end
    end

    // Event counters, wrap on overflow
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hits_q   <= '0;
            misses_q <= '0;
        end else begin
            if (cfg_we_i && cfg_addr_i == REG_HITS) begin
                hits_q <= '0;               // Any write clears
            end else if (hit_evt_i) begin
                hits_q <= hits_q + 1'b1;
            end
            if (cfg_we_i && cfg_addr_i == REG_MISSES) begin
                misses_q <= '0;
            end else if (miss_evt_i) begin
                misses_q <= misses_q + 1'b1;
            end
        end
    end

    // Read mux
    always_comb begin
        case (cfg_addr_i)
            REG_CTRL:   cfg_rdata_o = {{(`CACHE_DATA_W-2){1'b0}}, flush_q, enable_q};
            REG_HITS:   cfg_rdata_o = hits_q;
            REG_MISSES: cfg_rdata_o = misses_q;
            default:    cfg_rdata_o = '0;
        endcase
    end

    assign enable_o = enable_q;
    assign flush_o  = flush_q;

endmodule

// ==== design/l1_cache_top.sv ====
`include "cache_macros.svh"

module l1_cache_top
    import bus_pkg::*;
(
    input  logic                     clk,
    input  logic                     arst_n_i,
    // Core port
    input  logic                     req_i,
    input  logic [`CACHE_ADDR_W-1:0] addr_i,
    input  logic                     wr_en_i,
    input  access_size_e             size_i,
    input  logic [`CACHE_DATA_W-1:0] wr_data_i,
    output logic                     done_o,
    output logic [`CACHE_DATA_W-1:0] rd_data_o,
    // Memory port
    output logic                     mem_rd_o,
    output logic                     mem_wr_o,
    output logic [`CACHE_ADDR_W-1:0] mem_addr_o,
    output logic [`CACHE_DATA_W-1:0] mem_wdata_o,
    output access_size_e             mem_size_o,
    input  logic                     mem_valid_i,
    input  logic [`CACHE_DATA_W-1:0] mem_data_i,
    // Register port
    input  logic                     cfg_we_i,
    input  cfg_reg_e                 cfg_addr_i,
    input  logic [`CACHE_DATA_W-1:0] cfg_wdata_i,
    output logic [`CACHE_DATA_W-1:0] cfg_rdata_o
);

    logic                     hit;
    logic [`CACHE_DATA_W-1:0] array_rd_data;
    logic                     lookup;
    logic                     fill_en;
    logic [`CACHE_DATA_W-1:0] fill_data;
    logic                     enable;
    logic                     flush;
    logic                     hit_evt;
    logic                     miss_evt;

    l1_cache_array u_array (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .addr_i      (addr_i),
        .wr_en_i     (wr_en_i),
        .size_i      (size_i),
        .wr_data_i   (wr_data_i),
        .lookup_i    (lookup),
        .fill_en_i   (fill_en),
        .fill_data_i (fill_data),
        .flush_i     (flush),
        .hit_o       (hit),
        .rd_data_o   (array_rd_data)
    );

    miss_fetch u_fetch (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .req_i           (req_i),
        .wr_en_i         (wr_en_i),
        .addr_i          (addr_i),
        .wr_data_i       (wr_data_i),
        .size_i          (size_i),
        .enable_i        (enable),
        .hit_i           (hit),
        .array_rd_data_i (array_rd_data),
        .mem_valid_i     (mem_valid_i),
        .mem_data_i      (mem_data_i),
        .done_o          (done_o),
        .rd_data_o       (rd_data_o),
        .lookup_o        (lookup),
        .fill_en_o       (fill_en),
        .fill_data_o     (fill_data),
        .mem_rd_o        (mem_rd_o),
        .mem_wr_o        (mem_wr_o),
        .mem_addr_o      (mem_addr_o),
        .mem_wdata_o     (mem_wdata_o),
        .mem_size_o      (mem_size_o),
        .hit_evt_o       (hit_evt),
        .miss_evt_o      (miss_evt)
    );

    cache_cfg_regs u_regs (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .hit_evt_i   (hit_evt),
        .miss_evt_i  (miss_evt),
        .cfg_rdata_o (cfg_rdata_o),
        .enable_o    (enable),
        .flush_o     (flush)
    );

endmodule

// ==== sim/l1_cache_props.sv ====
module l1_cache_props
    import cache_pkg::*;
(
    input logic clk,
    input logic arst_n_i,
    input logic req_i,
    input logic done_i,
    input logic mem_rd_i,
    input logic mem_wr_i,
    input logic mem_valid_i,
    input logic fill_en_i
);

    timeunit 1ns;
    timeprecision 100ps;

    fetch_state_e rd_phase_q;   // FETCH_WAIT while a memory read is out

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_phase_q <= FETCH_IDLE;
        end else if (mem_rd_i) begin
            rd_phase_q <= FETCH_WAIT;
        end else if (mem_valid_i) begin
            rd_phase_q <= FETCH_IDLE;       // Answer closes the read
        end
    end

    a_single_read: assert property (@(posedge clk) disable iff (!arst_n_i)
        mem_rd_i |-> rd_phase_q == FETCH_IDLE)
        else $error("mem_rd_o issued while a read is outstanding");

    a_done_needs_req: assert property (@(posedge clk) disable iff (!arst_n_i)
        done_i |-> req_i)
        else $error("done_o high without req_i");

    // Outputs quiet while reset is held
    a_quiet_in_reset: assert property (@(posedge clk)
        !arst_n_i |-> !done_i && !mem_rd_i && !mem_wr_i)
        else $error("done_o, mem_rd_o or mem_wr_o high in reset");

    a_fill_on_valid: assert property (@(posedge clk) disable iff (!arst_n_i)
        fill_en_i |-> mem_valid_i)
        else $error("fill without mem_valid_i");

endmodule

bind l1_cache_top l1_cache_props u_props (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .req_i       (req_i),
    .done_i      (done_o),
    .mem_rd_i    (mem_rd_o),
    .mem_wr_i    (mem_wr_o),
    .mem_valid_i (mem_valid_i),
    .fill_en_i   (fill_en)
);

// ==== sim/l1_cache_tb.sv ====
`include "cache_macros.svh"

module l1_cache_tb
    import bus_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int                     ACCESS_TIMEOUT = 20;     // Worst miss is 5 cycles
    localparam logic [`CACHE_DATA_W-1:0] FILL_PATTERN = 32'h5EED_C0DE;

    logic                     clk;
    logic                     arst_n_i;
    logic                     req_i;
    logic [`CACHE_ADDR_W-1:0] addr_i;
    logic                     wr_en_i;
    access_size_e             size_i;
    logic [`CACHE_DATA_W-1:0] wr_data_i;
    logic                     done_o;
    logic [`CACHE_DATA_W-1:0] rd_data_o;
    logic                     mem_rd_o;
    logic                     mem_wr_o;
    logic [`CACHE_ADDR_W-1:0] mem_addr_o;
    logic [`CACHE_DATA_W-1:0] mem_wdata_o;
    access_size_e             mem_size_o;
    logic                     mem_valid_i;
    logic [`CACHE_DATA_W-1:0] mem_data_i;
    logic                     cfg_we_i;
    cfg_reg_e                 cfg_addr_i;
    logic [`CACHE_DATA_W-1:0] cfg_wdata_i;
    logic [`CACHE_DATA_W-1:0] cfg_rdata_o;

    logic [31:0] mem_model [logic [31:0]];  // Main memory, written words only
    logic [31:0] shadow    [logic [31:0]];  // Expected content of main memory
    logic        rd_pending;
    int          rd_wait;                   // Cycles left until mem_valid_i
    logic [31:0] rd_addr;

    int data_errs;
    int bit_errs;
    int count_errs;
    int timeout_errs;

    l1_cache_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] word_addr(input logic [31:0] addr);
        return {addr[31:2], 2'b00};
    endfunction

    // Low lanes only, zero-extended
    function automatic logic [31:0] mask_lanes(input logic [31:0] word, input access_size_e size);
        case (size)
            SIZE_BYTE: return word & 32'h0000_00FF;
            SIZE_HALF: return word & 32'h0000_FFFF;
            default:   return word;
        endcase
    endfunction

    function automatic logic [31:0] merge_lanes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input access_size_e size);
        logic [31:0] keep;
        keep = ~mask_lanes(32'hFFFF_FFFF, size);
        return (old_word & keep) | mask_lanes(new_word, size);
    endfunction

    function automatic logic [31:0] model_word(input logic [31:0] addr);
        logic [31:0] key;
        key = word_addr(addr);
        return mem_model.exists(key) ? mem_model[key] : (key ^ FILL_PATTERN);
    endfunction

    function automatic logic [31:0] shadow_word(input logic [31:0] addr);
        logic [31:0] key;
        key = word_addr(addr);
        return shadow.exists(key) ? shadow[key] : (key ^ FILL_PATTERN);
    endfunction

    // Memory strobes are settled by the falling edge
    always @(negedge clk) begin
        if (mem_wr_o) begin
            mem_model[word_addr(mem_addr_o)] = merge_lanes(model_word(mem_addr_o),
                                                           mem_wdata_o, mem_size_o);
        end
        if (mem_rd_o) begin
            rd_pending = 1'b1;
            rd_addr    = mem_addr_o;
            rd_wait    = $urandom_range(1, 4);   // Variable latency
        end
    end

    // Read answer, one-cycle valid
    always @(posedge clk) begin
        #1;
        mem_valid_i = 1'b0;
        if (rd_pending) begin
            rd_wait = rd_wait - 1;
            if (rd_wait == 0) begin
                mem_valid_i = 1'b1;
                mem_data_i  = model_word(rd_addr);
                rd_pending  = 1'b0;
            end
        end
    end

    task automatic check_data(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            data_errs++;
            $display("[FAIL] %s: expected 0x%08h, got 0x%08h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            bit_errs++;
            $display("[FAIL] %s: expected 0x%0h, got 0x%0h", name, exp, act);
        end
    endtask

    task automatic cfg_write(input cfg_reg_e addr, input logic [31:0] data);
        @(posedge clk);
        #1;
        cfg_we_i    = 1'b1;
        cfg_addr_i  = addr;
        cfg_wdata_i = data;
        @(posedge clk);
        #1;
        cfg_we_i    = 1'b0;
    endtask

    task automatic cfg_read(input cfg_reg_e addr, output logic [31:0] data);
        @(posedge clk);
        #1;
        cfg_addr_i = addr;
        @(negedge clk);
        data = cfg_rdata_o;                     // Combinational read
    endtask

    task automatic check_count(input cfg_reg_e addr, input logic [31:0] exp);
        logic [31:0] act;
        cfg_read(addr, act);
        if (exp !== act) begin
            count_errs++;
            $display("[FAIL] %s: expected 0x%08h, got 0x%08h", addr.name(), exp, act);
        end
    endtask

    // One core request, held until done_o
    task automatic do_access(input logic [31:0] addr, input logic wr, input access_size_e size,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic saw_rd);
        int   cycles;
        logic got_done;
        cycles   = 0;
        got_done = 1'b0;
        saw_rd   = 1'b0;
        rdata    = '0;
        @(posedge clk);
        #1;
        req_i     = 1'b1;
        addr_i    = addr;
        wr_en_i   = wr;
        size_i    = size;
        wr_data_i = wdata;
        while (!got_done && cycles < ACCESS_TIMEOUT) begin
            @(negedge clk);
            if (mem_rd_o) saw_rd = 1'b1;
            if (done_o) begin
                got_done = 1'b1;
                rdata    = rd_data_o;
            end
            cycles++;
        end
        @(posedge clk);
        #1;
        req_i   = 1'b0;                         // Drop in the cycle after done_o
        wr_en_i = 1'b0;
        if (!got_done) begin
            timeout_errs++;
            $display("Timeout: done_o did not arrive for address 0x%08h", addr);
        end else if (wr) begin
            shadow[word_addr(addr)] = merge_lanes(shadow_word(addr), wdata, size);
            check_data("mem_model word", shadow_word(addr), model_word(addr)); // Write-through
        end
    endtask

    task automatic read_and_compare(input logic [31:0] addr, input access_size_e size,
                                    input string name, output logic saw_rd);
        logic [31:0] rdata;
        do_access(addr, 1'b0, size, '0, rdata, saw_rd);
        check_data({"rd_data_o ", name}, mask_lanes(shadow_word(addr), size), rdata);
    endtask

    task automatic write_access(input logic [31:0] addr, input access_size_e size,
                                input logic [31:0] data);
        logic [31:0] unused_rd;
        logic        saw_rd;
        do_access(addr, 1'b1, size, data, unused_rd, saw_rd);
    endtask

    task automatic miss_then_hit();
        logic saw_rd;
        cfg_write(REG_CTRL, 32'h1);             // Enable
        read_and_compare(32'h0000_1230, SIZE_WORD, "first read", saw_rd);
        check_bit("mem_rd_o first read", 1'b1, saw_rd);
        read_and_compare(32'h0000_1230, SIZE_WORD, "repeat read", saw_rd);
        check_bit("mem_rd_o repeat read", 1'b0, saw_rd);
        check_count(REG_HITS, 32'd1);
        check_count(REG_MISSES, 32'd1);
    endtask

    task automatic access_sizes();
        logic saw_rd;
        write_access(32'h0000_2460, SIZE_WORD, 32'h1122_3344);
        write_access(32'h0000_2460, SIZE_BYTE, 32'hFFFF_FFAB);     // Upper bits ignored
        write_access(32'h0000_2460, SIZE_HALF, 32'h5A5A_CDEF);
        read_and_compare(32'h0000_2460, SIZE_BYTE, "byte read", saw_rd);
        read_and_compare(32'h0000_2460, SIZE_HALF, "half read", saw_rd);
        read_and_compare(32'h0000_2460, SIZE_WORD, "word read", saw_rd);
        read_and_compare(32'h0000_2463, SIZE_BYTE, "offset byte read", saw_rd);
    endtask

    // Five tags in set 0x20, spaced by the index span
    task automatic lru_replacement();
        logic [31:0] misses;
        logic        saw_rd;
        for (int k = 0; k < 4; k++) begin
            read_and_compare(32'h0000_3080 + 32'h400 * k, SIZE_WORD, "lru fill", saw_rd);
        end
        read_and_compare(32'h0000_3080, SIZE_WORD, "lru touch", saw_rd);
        read_and_compare(32'h0000_4080, SIZE_WORD, "fifth tag", saw_rd);   // Evicts tag 1
        read_and_compare(32'h0000_3080, SIZE_WORD, "tag 0", saw_rd);
        check_bit("mem_rd_o tag 0", 1'b0, saw_rd);
        read_and_compare(32'h0000_3880, SIZE_WORD, "tag 2", saw_rd);
        check_bit("mem_rd_o tag 2", 1'b0, saw_rd);
        read_and_compare(32'h0000_3C80, SIZE_WORD, "tag 3", saw_rd);
        check_bit("mem_rd_o tag 3", 1'b0, saw_rd);
        cfg_read(REG_MISSES, misses);
        read_and_compare(32'h0000_3480, SIZE_WORD, "tag 1", saw_rd);
        check_bit("mem_rd_o tag 1", 1'b1, saw_rd);
        check_count(REG_MISSES, misses + 32'd1);
    endtask

    task automatic flush_invalidates();
        logic saw_rd;
        read_and_compare(32'h0000_1230, SIZE_WORD, "before flush", saw_rd);
        check_bit("mem_rd_o before flush", 1'b0, saw_rd);
        read_and_compare(32'h0000_2460, SIZE_WORD, "before flush", saw_rd);
        check_bit("mem_rd_o before flush", 1'b0, saw_rd);
        cfg_write(REG_CTRL, 32'h3);             // Stay enabled, flush pulse
        read_and_compare(32'h0000_1230, SIZE_WORD, "after flush", saw_rd);
        check_bit("mem_rd_o after flush", 1'b1, saw_rd);
        read_and_compare(32'h0000_2460, SIZE_WORD, "after flush", saw_rd);
        check_bit("mem_rd_o after flush", 1'b1, saw_rd);
    endtask

    task automatic bypass_when_disabled();
        logic [31:0] hits;
        logic [31:0] misses;
        logic        saw_rd;
        cfg_write(REG_CTRL, 32'h0);
        cfg_read(REG_HITS, hits);
        cfg_read(REG_MISSES, misses);
        read_and_compare(32'h0000_1230, SIZE_WORD, "bypass word", saw_rd);   // Cached line
        check_bit("mem_rd_o bypass word", 1'b1, saw_rd);
        read_and_compare(32'h0000_1230, SIZE_BYTE, "bypass byte", saw_rd);
        check_bit("mem_rd_o bypass byte", 1'b1, saw_rd);
        write_access(32'h0000_5554, SIZE_HALF, 32'h1234_BEEF);
        read_and_compare(32'h0000_5554, SIZE_HALF, "bypass half", saw_rd);
        check_bit("mem_rd_o bypass half", 1'b1, saw_rd);
        check_count(REG_HITS, hits);
        check_count(REG_MISSES, misses);
    endtask

    // Six tags over sets 0x40 to 0x43
    task automatic random_mix();
        logic [31:0]  addr;
        logic [31:0]  hits;
        logic [31:0]  misses;
        logic         saw_rd;
        access_size_e size;
        cfg_write(REG_CTRL, 32'h3);
        cfg_write(REG_HITS, 32'h0);
        cfg_write(REG_MISSES, 32'h0);
        for (int n = 0; n < 200; n++) begin
            addr = ($urandom_range(0, 5) << 10) | ((32'h40 + $urandom_range(0, 3)) << 2)
                 | $urandom_range(0, 3);
            size = access_size_e'($urandom_range(0, 2));
            if ($urandom_range(0, 2) == 0) write_access(addr, size, $urandom);
            else read_and_compare(addr, size, "random read", saw_rd);
        end
        cfg_read(REG_HITS, hits);
        cfg_read(REG_MISSES, misses);
        check_data("hits plus misses", 32'd200, hits + misses);
    endtask

    initial begin
        void'($urandom(10974));
        arst_n_i     = 1'b0;
        req_i        = 1'b0;
        addr_i       = '0;
        wr_en_i      = 1'b0;
        size_i       = SIZE_WORD;
        wr_data_i    = '0;
        mem_valid_i  = 1'b0;
        mem_data_i   = '0;
        cfg_we_i     = 1'b0;
        cfg_addr_i   = REG_CTRL;
        cfg_wdata_i  = '0;
        rd_pending   = 1'b0;
        rd_wait      = 0;
        rd_addr      = '0;
        data_errs    = 0;
        bit_errs     = 0;
        count_errs   = 0;
        timeout_errs = 0;
        repeat (10) @(posedge clk);
        #1 arst_n_i = 1'b1;
        miss_then_hit();
        access_sizes();
        lru_replacement();
        flush_invalidates();
        bypass_when_disabled();
        random_mix();
        $display("Errors: data %0d, flag %0d, counter %0d, timeout %0d",
                 data_errs, bit_errs, count_errs, timeout_errs);
        if (data_errs + bit_errs + count_errs + timeout_errs == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+design
design/cache_pkg.sv
design/bus_pkg.sv
design/l1_cache_array.sv
design/miss_fetch.sv
design/cache_cfg_regs.sv
design/l1_cache_top.sv
sim/l1_cache_props.sv
sim/l1_cache_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module l1_cache_tb \
    -o l1_cache_sim \
    && ./obj_dir/l1_cache_sim | tee /dev/stderr | grep -q "^Result: PASSED$" \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }
